//--- source/sbox_field_pkg.sv
package sbox_field_pkg;

  ////////////////////////////////////////
  // Base field GF(2^2)
  ////////////////////////////////////////

  // Normal basis, so squaring is a bit swap.
  localparam int GF4_WIDTH = 2;

  typedef logic [GF4_WIDTH-1:0] gf4_t;

  ////////////////////////////////////////
  // Symbol field GF(2^6)
  ////////////////////////////////////////

  // Tower GF((2^2)^3), three base coefficients.
  localparam int GF4_PER_GF64 = 3;
  localparam int GF64_WIDTH   = GF4_WIDTH * GF4_PER_GF64;

  // Polynomial or tower basis, same width.
  typedef logic [GF64_WIDTH-1:0] gf64_t;

endpackage

//--- source/sbox_stream_pkg.sv
package sbox_stream_pkg;

  ////////////////////////////////////////
  // Word layout
  ////////////////////////////////////////

  typedef sbox_field_pkg::gf64_t symbol_t;

  localparam int SYMBOL_WIDTH     = $bits(symbol_t);
  localparam int SYMBOLS_PER_WORD = 4;
  localparam int WORD_WIDTH       = SYMBOLS_PER_WORD * SYMBOL_WIDTH;

  typedef logic [WORD_WIDTH-1:0] word_t; // Symbol k in bits 6k+5:6k.

  ////////////////////////////////////////
  // Flow control
  ////////////////////////////////////////

  localparam int IN_DEPTH    = 4; // Also the upstream credits after reset.
  localparam int OUT_CREDITS = 3;

  typedef logic [$clog2(IN_DEPTH)-1:0]    in_ptr_t;
  typedef logic [$clog2(IN_DEPTH+1)-1:0]  in_count_t;
  typedef logic [$clog2(OUT_CREDITS+1)-1:0] credit_count_t;

endpackage

//--- source/sbox_power34.sv
`timescale 1ns/1ps
module sbox_power34 (
  input  sbox_field_pkg::gf64_t x,
  output sbox_field_pkg::gf64_t y
);
  import sbox_field_pkg::*;

  function automatic gf4_t gf4_sq(input gf4_t a);
    gf4_sq = {a[0], a[1]};
  endfunction

  function automatic gf4_t gf4_mul(input gf4_t a, input gf4_t b);
    logic t;
    t = (a[0] & b[1]) ^ (a[1] & b[0]);
    gf4_mul = {(a[0] & b[0]) ^ t, (a[1] & b[1]) ^ t};
  endfunction

  gf64_t w; // Tower basis input.
  gf64_t p; // Tower basis result.
  gf4_t  c [GF4_PER_GF64];
  gf4_t  s [GF4_PER_GF64];
  gf4_t  m01;
  gf4_t  m02;
  gf4_t  m12;

  ////////////////////////////////////////
  // Polynomial to tower basis
  ////////////////////////////////////////

  assign w[0] = x[0] ^ x[1];
  assign w[1] = x[4] ^ x[5];
  assign w[2] = x[2] ^ x[4] ^ x[5];
  assign w[3] = x[5];
  assign w[4] = x[0] ^ x[3];
  assign w[5] = x[1] ^ x[2] ^ x[5];

  ////////////////////////////////////////
  // x^34 in GF((2^2)^3)
  ////////////////////////////////////////

  for (genvar i = 0; i < GF4_PER_GF64; i++) begin : g_coef
    assign c[i] = w[i*$bits(gf4_t) +: $bits(gf4_t)];
    assign s[i] = gf4_sq(c[i]);
  end

  assign m01 = gf4_mul(s[0], s[1]);
  assign m02 = gf4_mul(s[0], s[2]);
  assign m12 = gf4_mul(s[1], s[2]);

  assign p[1:0] = m12 ^ c[0] ^ c[1];
  assign p[3:2] = m02 ^ c[1] ^ c[2];
  assign p[5:4] = m01 ^ c[0] ^ c[2];

  // Back to the polynomial basis.
  assign y[0] = p[4];
  assign y[1] = p[0] ^ p[1] ^ p[2];
  assign y[2] = p[0];
  assign y[3] = p[3] ^ p[4];
  assign y[4] = p[0] ^ p[2] ^ p[3] ^ p[4];
  assign y[5] = p[0] ^ p[4] ^ p[5];

endmodule

//--- source/sbox_layer.sv
`timescale 1ns/1ps
module sbox_layer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   load,
  input  sbox_stream_pkg::word_t in_word,
  output logic                   out_valid,
  output sbox_stream_pkg::word_t out_word
);
  import sbox_stream_pkg::*;

  word_t sub_word;

  for (genvar k = 0; k < SYMBOLS_PER_WORD; k++) begin : g_sym
    symbol_t sym_in;
    symbol_t sym_out;

    assign sym_in = in_word[k*SYMBOL_WIDTH +: SYMBOL_WIDTH];

    sbox_power34 u_sbox (
      .x (sym_in),
      .y (sym_out)
    );

    assign sub_word[k*SYMBOL_WIDTH +: SYMBOL_WIDTH] = sym_out;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= load; // One cycle behind the issue.
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_word <= sub_word;
    end
  end

endmodule

//--- source/credit_fifo.sv
`timescale 1ns/1ps
module credit_fifo (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   push,
  input  sbox_stream_pkg::word_t push_data,
  input  logic                   pop,
  output logic                   not_empty,
  output sbox_stream_pkg::word_t head_data,
  output logic                   credit_return
);
  import sbox_stream_pkg::*;

  function automatic in_ptr_t ptr_next(input in_ptr_t ptr);
    ptr_next = (ptr == in_ptr_t'(IN_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  word_t     mem [IN_DEPTH];
  in_ptr_t   wr_ptr;
  in_ptr_t   rd_ptr;
  in_count_t count;

  ////////////////////////////////////////
  // Pointers and fill level
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      credit_return <= pop; // Slot freed, hand the credit back.
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  assign not_empty = (count != '0);
  assign head_data = mem[rd_ptr]; // First word out.

  ////////////////////////////////////////
  // Protocol checks
  ////////////////////////////////////////

  // Upstream sent a word without holding a credit.
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    push |-> (count < IN_DEPTH))
    else $error("credit_fifo: push while full, count=%0d", count);

  // Issue control popped an empty buffer.
  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    pop |-> not_empty)
    else $error("credit_fifo: pop while empty");

endmodule

//--- source/credit_sender.sv
`timescale 1ns/1ps
module credit_sender (
  input  logic clk,
  input  logic rst,
  input  logic ready_word,
  input  logic credit_in,
  output logic issue
);
  import sbox_stream_pkg::*;

  credit_count_t credits;

  assign issue = ready_word && (credits != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= credit_count_t'(OUT_CREDITS);
    end else begin
      case ({credit_in, issue})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits; // Return and spend cancel.
      endcase
    end
  end

  ////////////////////////////////////////
  // Credit checks
  ////////////////////////////////////////

  // Downstream never returns more credits than it was sent words.
  a_credit_limit: assert property (@(posedge clk) disable iff (rst)
    (credit_in && !issue) |-> (credits < OUT_CREDITS))
    else $error("credit_sender: credit overflow, credits=%0d", credits);

endmodule

//--- source/sbox_stream_top.sv
`timescale 1ns/1ps
module sbox_stream_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_valid,
  input  sbox_stream_pkg::word_t in_data,
  output logic                   in_credit,
  output logic                   out_valid,
  output sbox_stream_pkg::word_t out_data,
  input  logic                   out_credit
);
  import sbox_stream_pkg::*;

  logic  not_empty;
  logic  issue;     // Pop and load in one.
  word_t head_data;

  credit_fifo u_in_fifo (
    .clk           (clk),
    .rst           (rst),
    .push          (in_valid),
    .push_data     (in_data),
    .pop           (issue),
    .not_empty     (not_empty),
    .head_data     (head_data),
    .credit_return (in_credit)
  );

  credit_sender u_out_credits (
    .clk        (clk),
    .rst        (rst),
    .ready_word (not_empty),
    .credit_in  (out_credit),
    .issue      (issue)
  );

  sbox_layer u_sbox_layer (
    .clk       (clk),
    .rst       (rst),
    .load      (issue),
    .in_word   (head_data),
    .out_valid (out_valid),
    .out_word  (out_data)
  );

endmodule

//--- include/sbox_tb_vectors.svh
`ifndef SBOX_TB_VECTORS_SVH
`define SBOX_TB_VECTORS_SVH

////////////////////////////////////////
// Directed words
////////////////////////////////////////

// Symbol 3 is written first in each word.
localparam int NUM_VECTORS = 8;

localparam sbox_stream_pkg::word_t VEC_IN [NUM_VECTORS] = '{
  {6'h00, 6'h00, 6'h00, 6'h00}, // All zero symbols.
  {6'h01, 6'h02, 6'h03, 6'h04},
  {6'h3F, 6'h2A, 6'h15, 6'h00},
  {6'h10, 6'h20, 6'h30, 6'h3F},
  {6'h05, 6'h0A, 6'h14, 6'h28},
  {6'h3E, 6'h3D, 6'h07, 6'h11},
  {6'h1C, 6'h23, 6'h2D, 6'h36},
  {6'h09, 6'h18, 6'h27, 6'h33}
};

localparam sbox_stream_pkg::word_t VEC_EXP [NUM_VECTORS] = '{
  {6'h00, 6'h00, 6'h00, 6'h00},
  {6'h36, 6'h3D, 6'h13, 6'h28},
  {6'h30, 6'h3B, 6'h34, 6'h00},
  {6'h1F, 6'h33, 6'h20, 6'h30},
  {6'h1B, 6'h04, 6'h02, 6'h10},
  {6'h2E, 6'h11, 6'h39, 6'h2C},
  {6'h23, 6'h06, 6'h0E, 6'h15},
  {6'h0F, 6'h08, 6'h2F, 6'h05}
};

////////////////////////////////////////
// Full S-box, indexed by input symbol
////////////////////////////////////////

localparam sbox_stream_pkg::symbol_t SBOX_REF [64] = '{
  6'h00, 6'h36, 6'h3D, 6'h13, 6'h28, 6'h1B, 6'h12, 6'h39,
  6'h2B, 6'h0F, 6'h04, 6'h38, 6'h35, 6'h14, 6'h1D, 6'h24,
  6'h1F, 6'h2C, 6'h37, 6'h1C, 6'h02, 6'h34, 6'h2D, 6'h03,
  6'h08, 6'h29, 6'h32, 6'h0B, 6'h23, 6'h07, 6'h1E, 6'h22,
  6'h33, 6'h27, 6'h0A, 6'h06, 6'h18, 6'h09, 6'h26, 6'h2F,
  6'h10, 6'h16, 6'h3B, 6'h25, 6'h0D, 6'h0E, 6'h21, 6'h3A,
  6'h20, 6'h31, 6'h0C, 6'h05, 6'h3E, 6'h2A, 6'h15, 6'h19,
  6'h3F, 6'h3C, 6'h01, 6'h1A, 6'h17, 6'h11, 6'h2E, 6'h30
};

`endif

//--- test/sbox_stream_tb.sv
`timescale 1ns/1ps
module sbox_stream_tb;
  import sbox_stream_pkg::*;

  `include "sbox_tb_vectors.svh"

  localparam int EXH_WORDS      = 64 / SYMBOLS_PER_WORD;
  localparam int BP_WORDS       = 6;
  localparam int BURST_WORDS    = 100;
  localparam int TOTAL_WORDS    = NUM_VECTORS + EXH_WORDS + BP_WORDS + BURST_WORDS;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_WORDS + 200;

  logic  clk;
  logic  rst;
  logic  in_valid;
  word_t in_data;
  logic  in_credit;
  logic  out_valid;
  word_t out_data;
  logic  out_credit;

  integer seed;
  int     cycle;
  int     errors;
  int     tests_run;
  int     tests_failed;
  int     up_credits;    // Upstream model's credit count.
  int     words_sent;
  int     credit_pulses; // in_credit pulses seen.
  int     rx_count;
  bit     withhold;      // Downstream keeps its credits.
  word_t  exp_q [$];
  word_t  rx_log [$];
  int     due_q [$];     // Cycle at which each credit goes back.

  sbox_stream_top DUT (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_credit (out_credit)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////
  // Models and helpers
  ////////////////////////////////////////

  function automatic word_t expected_word(input word_t w);
    word_t r;
    for (int k = 0; k < SYMBOLS_PER_WORD; k++) begin
      r[k*SYMBOL_WIDTH +: SYMBOL_WIDTH] = SBOX_REF[w[k*SYMBOL_WIDTH +: SYMBOL_WIDTH]];
    end
    return r;
  endfunction

  // Starts and ends on a falling edge.
  task automatic send_word(input word_t w, input word_t want);
    while (up_credits == 0) @(negedge clk);
    in_valid = 1'b1;
    in_data  = w;
    up_credits--;
    words_sent++;
    exp_q.push_back(want);
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk); // Last in_credit pulse.
  endtask

  task automatic wait_credits_home();
    while (due_q.size() != 0) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("%s: FAIL, %0d errors", name, errors - err_before);
    end else begin
      $display("%s: PASS", name);
    end
  endtask

  always @(posedge clk) begin : monitor
    word_t want;
    if (!rst) begin
      cycle++;
      if (in_credit) begin
        up_credits++;
        credit_pulses++;
        if (up_credits > IN_DEPTH) begin
          errors++;
          $display("in_credit returned a credit that upstream never spent");
        end
      end
      if (out_valid) begin
        rx_count++;
        rx_log.push_back(out_data);
        due_q.push_back(cycle + $unsigned($random(seed)) % 6); // 0 to 5 cycles.
        if (exp_q.size() == 0) begin
          errors++;
          $display("Word %h arrived with no word outstanding", out_data);
        end else begin
          want = exp_q.pop_front();
          if (out_data !== want) begin
            errors++;
            $display("[FAIL] out_data got %h expected %h", out_data, want);
          end
        end
      end
    end
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, words still outstanding: %0d", cycle, exp_q.size());
      $display("Test failed");
      $finish;
    end
  end

  always @(negedge clk) begin
    out_credit = 1'b0;
    if (!rst && !withhold && due_q.size() != 0 && due_q[0] <= cycle) begin
      void'(due_q.pop_front());
      out_credit = 1'b1; // One credit per cycle at most.
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin : stimulus
    int      err0;
    int      base;
    int      pulses0;
    int      sent0;
    int      wait_cycles;
    word_t   w;
    bit      seen [64];
    symbol_t sym;

    clk           = 1'b0;
    rst           = 1'b1;
    in_valid      = 1'b0;
    in_data       = '0;
    out_credit    = 1'b0;
    withhold      = 1'b0;
    seed          = 9;
    cycle         = 0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    up_credits    = IN_DEPTH;
    words_sent    = 0;
    credit_pulses = 0;
    rx_count      = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    err0 = errors;
    repeat (5) begin
      @(posedge clk);
      if (out_valid !== 1'b0) begin
        errors++;
        $display("[FAIL] out_valid got %h expected 0", out_valid);
      end
      if (in_credit !== 1'b0) begin
        errors++;
        $display("[FAIL] in_credit got %h expected 0", in_credit);
      end
    end
    @(negedge clk);
    finish_test("reset state", err0);

    err0 = errors;
    for (int i = 0; i < NUM_VECTORS; i++) begin
      send_word(VEC_IN[i], VEC_EXP[i]);
    end
    wait_drain();
    finish_test("table vectors", err0);

    err0 = errors;
    rx_log.delete();
    for (int i = 0; i < 64; i++) begin
      seen[i] = 1'b0;
    end
    for (int i = 0; i < EXH_WORDS; i++) begin
      for (int k = 0; k < SYMBOLS_PER_WORD; k++) begin
        w[k*SYMBOL_WIDTH +: SYMBOL_WIDTH] = symbol_t'(i * SYMBOLS_PER_WORD + k);
      end
      send_word(w, expected_word(w));
    end
    wait_drain();
    if (rx_log.size() != EXH_WORDS) begin
      errors++;
      $display("Got %0d words for the full S-box sweep, expected %0d", rx_log.size(), EXH_WORDS);
    end
    foreach (rx_log[j]) begin
      for (int k = 0; k < SYMBOLS_PER_WORD; k++) begin
        sym = rx_log[j][k*SYMBOL_WIDTH +: SYMBOL_WIDTH];
        if (seen[sym]) begin
          errors++;
          $display("S-box output %h appears more than once", sym);
        end
        seen[sym] = 1'b1;
      end
    end
    finish_test("exhaustive S-box", err0);

    wait_credits_home();
    err0 = errors;
    base = rx_count;
    @(posedge clk);
    withhold = 1'b1;
    @(negedge clk);
    for (int i = 0; i < BP_WORDS; i++) begin
      w = word_t'($random(seed));
      send_word(w, expected_word(w));
    end
    wait_cycles = 0;
    while (rx_count - base < OUT_CREDITS && wait_cycles < 50) begin
      @(negedge clk);
      wait_cycles++;
    end
    repeat (20) begin
      @(posedge clk);
      if (out_valid) begin
        errors++;
        $display("A word came out while downstream held no credit");
      end
    end
    @(negedge clk);
    if (rx_count - base != OUT_CREDITS) begin
      errors++;
      $display("[FAIL] words before stall got %h expected %h", rx_count - base, OUT_CREDITS);
    end
    @(posedge clk);
    withhold = 1'b0;
    @(negedge clk);
    wait_drain();
    if (rx_count - base != BP_WORDS) begin
      errors++;
      $display("[FAIL] words after release got %h expected %h", rx_count - base, BP_WORDS);
    end
    finish_test("downstream back-pressure", err0);

    err0    = errors;
    pulses0 = credit_pulses;
    sent0   = words_sent;
    for (int i = 0; i < BURST_WORDS; i++) begin
      if ($unsigned($random(seed)) % 4 == 0) begin
        @(negedge clk); // Idle gap.
      end
      w = word_t'($random(seed));
      send_word(w, expected_word(w));
    end
    wait_drain();
    if (credit_pulses - pulses0 != words_sent - sent0) begin
      errors++;
      $display("[FAIL] in_credit pulses got %h expected %h",
               credit_pulses - pulses0, words_sent - sent0);
    end
    if (up_credits != IN_DEPTH) begin
      errors++;
      $display("[FAIL] upstream credits got %h expected %h", up_credits, IN_DEPTH);
    end
    finish_test("upstream credit conservation", err0);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+include
source/sbox_field_pkg.sv
source/sbox_stream_pkg.sv
source/sbox_power34.sv
source/sbox_layer.sv
source/credit_fifo.sv
source/credit_sender.sv
source/sbox_stream_top.sv
test/sbox_stream_tb.sv
